/* all.f */
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/decode_if.sv
verilog/regfile.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/exe_stage.sv
verilog/cpu.sv
tb/cpu_assertions.sv
tb/tb_cpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_cpu -f all.f -o tb_cpu_sim \
  && ./obj_dir/tb_cpu_sim \
  || exit 1

/* tb/tb_cpu.sv */
// testbench for cpu: clock, reset, fetch-port model, program table, compare tasks, timeout
`timescale 1ns/1ps

module tb_cpu import rv_isa_pkg::*, core_pkg::*; ();

  // base isa encodings
  localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [6:0]  OPC_LUI    = 7'b0110111;
  localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
  localparam logic [6:0]  OPC_JAL    = 7'b1101111;
  localparam inst_t       PUTCH_WORD = 32'h0000_007b;
  localparam xlen_t       START_PC   = 64'h8000_0000;
  localparam logic [31:0] LFSR_SEED  = 32'hc58d_e819;
  localparam reg_idx_t    X0 = 5'd0;
  localparam reg_idx_t    X1 = 5'd1;
  localparam reg_idx_t    X5 = 5'd5;
  localparam reg_idx_t    X6 = 5'd6;
  localparam reg_idx_t    X7 = 5'd7;
  localparam reg_idx_t    A0 = 5'd10;

  typedef struct packed {
    xlen_t      addr;
    inst_t      inst;
    logic       putch;
    logic [7:0] ch;
  } row_t;

  logic       i_clk = 1'b0;
  logic       i_rst_n;
  logic       o_imem_req;
  xlen_t      o_imem_addr;
  logic       i_imem_ack;
  inst_t      i_imem_rdata;
  logic       o_putch_valid;
  logic [7:0] o_putch_data;

  row_t        rows[$];
  xlen_t       end_addr;
  logic [31:0] lfsr;
  int          cycle_cnt = 0;
  int          cycle_limit;
  int          putch_cnt;
  logic [7:0]  putch_byte;

  cpu u_cpu (
    .i_clk         (i_clk        ),
    .i_rst_n       (i_rst_n      ),
    .o_imem_req    (o_imem_req   ),
    .o_imem_addr   (o_imem_addr  ),
    .i_imem_ack    (i_imem_ack   ),
    .i_imem_rdata  (i_imem_rdata ),
    .o_putch_valid (o_putch_valid),
    .o_putch_data  (o_putch_data )
  );

  always #5 i_clk = ~i_clk;

  //////////////////////////////
  // instruction encoders
  function automatic inst_t enc_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_lui(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic inst_t enc_br(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_jal(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_delay(output int d);
    d = 0;
    for (int b = 0; b < 2; b++) begin
      d = d | (int'(lfsr[0]) << b);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_row(ref xlen_t pc, input inst_t inst, input logic putch,
                         input logic [7:0] ch);
    rows.push_back('{addr: pc, inst: inst, putch: putch, ch: ch});
    pc = pc + 64'd4;
  endtask

  //////////////////////////////
  // program and expected results
  task automatic build_program();
    xlen_t pc;
    xlen_t v5;
    xlen_t v6;
    xlen_t v7;
    xlen_t r;
    pc = START_PC;
    v5 = 64'h0000_0000_1234_5000;
    v6 = 64'h7c;
    v7 = 64'h13;
    add_row(pc, enc_addi(X0, X0, 12'd5), 1'b0, 8'h00);
    // a0 = x0 + 0x41 only holds if x0 still reads zero
    add_row(pc, enc_addi(A0, X0, 12'h041), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, 8'h41);
    add_row(pc, enc_lui(X5, 20'h12345), 1'b0, 8'h00);
    add_row(pc, enc_addi(X6, X0, 12'h07c), 1'b0, 8'h00);
    add_row(pc, enc_addi(X7, X0, 12'h013), 1'b0, 8'h00);
    r = v5 + v6;
    add_row(pc, enc_r(7'b0000000, 3'b000, A0, X5, X6), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    r = v7 - v6;
    add_row(pc, enc_r(7'b0100000, 3'b000, A0, X7, X6), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    r = v6 & v7;
    add_row(pc, enc_r(7'b0000000, 3'b111, A0, X6, X7), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    r = v6 | v7;
    add_row(pc, enc_r(7'b0000000, 3'b110, A0, X6, X7), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    r = v6 ^ v7;
    add_row(pc, enc_r(7'b0000000, 3'b100, A0, X6, X7), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    // beq taken to pc + 12, then bne falls through
    add_row(pc, enc_br(3'b000, X6, X6, 13'd12), 1'b0, 8'h00);
    pc = pc - 64'd4 + 64'd12;
    add_row(pc, enc_br(3'b001, X6, X6, 13'd8), 1'b0, 8'h00);
    r = pc + 64'd4;
    add_row(pc, enc_jal(X1, 21'd16), 1'b0, 8'h00);
    pc = pc - 64'd4 + 64'd16;
    add_row(pc, enc_r(7'b0000000, 3'b000, A0, X1, X0), 1'b0, 8'h00);
    add_row(pc, PUTCH_WORD, 1'b1, r[7:0]);
    end_addr = pc;
  endtask

  //////////////////////////////
  // checks
  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_addr(input string sig, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: time %0t %s got %h expected %h",
                                $time, sig, got, exp));
    end
  endtask

  task automatic check_putch(input string sig, input logic [7:0] got,
                             input logic [7:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: time %0t %s got %h expected %h",
                                $time, sig, got, exp));
    end
  endtask

  task automatic check_strobe(input row_t r);
    if (r.putch && putch_cnt == 0) begin
      stop_with_error($sformatf("no putch strobe for the putch at %h", r.addr));
    end else if (!r.putch && putch_cnt != 0) begin
      stop_with_error($sformatf("putch strobe after the non-putch at %h", r.addr));
    end else if (putch_cnt > 1) begin
      stop_with_error($sformatf("putch strobe at %h lasted %0d cycles", r.addr, putch_cnt));
    end else if (r.putch) begin
      check_putch("o_putch_data", putch_byte, r.ch);
    end
  endtask

  // samples once per edge until the next fetch request, counting strobes
  task automatic wait_request();
    putch_cnt  = 0;
    putch_byte = 8'h00;
    do begin
      @(posedge i_clk);
      if (o_putch_valid) begin
        putch_cnt++;
        putch_byte = o_putch_data;
      end
    end while (!o_imem_req);
  endtask

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_with_error($sformatf("timeout: the program did not finish in %0d cycles",
                                cycle_limit));
    end
  end

  //////////////////////////////
  // main sequence
  initial begin
    int d;
    i_rst_n      = 1'b0;
    i_imem_ack   = 1'b0;
    i_imem_rdata = '0;
    lfsr         = LFSR_SEED;
    build_program();
    cycle_limit = 8 + 8 * rows.size() + 20;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      wait_request();
      if (i == 0 && putch_cnt != 0) begin
        stop_with_error("putch strobe before the first fetch");
      end else if (i != 0) begin
        check_strobe(rows[i-1]);
      end
      check_addr("o_imem_addr", o_imem_addr, rows[i].addr);
      take_delay(d);
      repeat (d) @(posedge i_clk);
      i_imem_ack   <= 1'b1;
      i_imem_rdata <= rows[i].inst;
      @(posedge i_clk);
      i_imem_ack   <= 1'b0;
      i_imem_rdata <= '0;
    end
    wait_request();
    check_strobe(rows[rows.size()-1]);
    check_addr("o_imem_addr", o_imem_addr, end_addr);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* tb/cpu_assertions.sv */
// concurrent checks on the fetch port and putch strobe, bound into cpu
`timescale 1ns/1ps

module cpu_assertions import core_pkg::*; (
  input logic  i_clk,
  input logic  i_rst_n,
  input logic  i_imem_req,
  input logic  i_imem_ack,
  input xlen_t i_imem_addr,
  input logic  i_putch_valid
);

  // request waits for its ack
  req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_imem_req && !i_imem_ack) |=> i_imem_req)
    else $error("fetch request dropped before acknowledge");

  addr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_imem_req && !i_imem_ack) |=> $stable(i_imem_addr))
    else $error("fetch address changed while waiting");

  addr_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_imem_req |-> (i_imem_addr[1:0] == 2'b00))
    else $error("fetch address not 4-aligned");

  putch_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_putch_valid |=> !i_putch_valid)
    else $error("putch strobe held for two cycles");

endmodule

bind cpu cpu_assertions u_cpu_assertions (
  .i_clk         (i_clk        ),
  .i_rst_n       (i_rst_n      ),
  .i_imem_req    (o_imem_req   ),
  .i_imem_ack    (i_imem_ack   ),
  .i_imem_addr   (o_imem_addr  ),
  .i_putch_valid (o_putch_valid)
);

/* verilog/cpu.sv */
// cpu top: fetch, decode, execute stages and register file
`timescale 1ns/1ps

module cpu import rv_isa_pkg::*, core_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h8000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst_n,

  // instruction fetch port
  output logic        o_imem_req,
  output xlen_t       o_imem_addr,
  input  logic        i_imem_ack,
  input  inst_t       i_imem_rdata,

  // putch a0
  output logic        o_putch_valid,
  output logic [7:0]  o_putch_data
);

  xlen_t    if_pc;
  inst_t    if_inst;
  logic     decode_en;
  logic     exec_en;
  xlen_t    pc_next;

  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  xlen_t    rs1_data;
  xlen_t    rs2_data;

  reg_idx_t ex_rd;
  logic     ex_rd_wen;
  xlen_t    ex_rd_wdata;

  decode_if u_dec_if ();

  //////////////////////////////
  // stages
  if_stage #(
    .RESET_PC                   (RESET_PC                   )
  ) u_if_stage (
    .i_clk                      (i_clk                      ),
    .i_rst_n                    (i_rst_n                    ),
    .o_imem_req                 (o_imem_req                 ),
    .o_imem_addr                (o_imem_addr                ),
    .i_imem_ack                 (i_imem_ack                 ),
    .i_imem_rdata               (i_imem_rdata               ),
    .i_pc_next                  (pc_next                    ),
    .o_pc                       (if_pc                      ),
    .o_inst                     (if_inst                    ),
    .o_decode_en                (decode_en                  ),
    .o_exec_en                  (exec_en                    )
  );

  id_stage u_id_stage (
    .i_clk                      (i_clk                      ),
    .i_rst_n                    (i_rst_n                    ),
    .i_decode_en                (decode_en                  ),
    .i_pc                       (if_pc                      ),
    .i_inst                     (if_inst                    ),
    .o_rs1                      (id_rs1                     ),
    .o_rs2                      (id_rs2                     ),
    .i_rs1_data                 (rs1_data                   ),
    .i_rs2_data                 (rs2_data                   ),
    .dec                        (u_dec_if.dec_mp            )
  );

  exe_stage u_exe_stage (
    .i_exec_en                  (exec_en                    ),
    .dec                        (u_dec_if.exe_mp            ),
    .o_rd                       (ex_rd                      ),
    .o_rd_wen                   (ex_rd_wen                  ),
    .o_rd_wdata                 (ex_rd_wdata                ),
    .o_pc_next                  (pc_next                    ),
    .o_putch_valid              (o_putch_valid              ),
    .o_putch_data               (o_putch_data               )
  );

  regfile u_regfile (
    .i_clk                      (i_clk                      ),
    .i_rst_n                    (i_rst_n                    ),
    .i_rs1                      (id_rs1                     ),
    .i_rs2                      (id_rs2                     ),
    .o_rs1_data                 (rs1_data                   ),
    .o_rs2_data                 (rs2_data                   ),
    .i_rd                       (ex_rd                      ),
    .i_rd_wen                   (ex_rd_wen                  ),
    .i_rd_wdata                 (ex_rd_wdata                )
  );

endmodule

/* verilog/exe_stage.sv */
// execute stage: alu, branch compare, next pc, register write and putch strobe
`timescale 1ns/1ps

module exe_stage import rv_isa_pkg::*, core_pkg::*; (
  input  logic          i_exec_en,
  decode_if.exe_mp      dec,
  output reg_idx_t      o_rd,
  output logic          o_rd_wen,
  output xlen_t         o_rd_wdata,
  output xlen_t         o_pc_next,
  output logic          o_putch_valid,
  output logic [7:0]    o_putch_data
);

  xlen_t alu_res;
  xlen_t pc_plus4;
  xlen_t pc_target;
  logic  br_eq;
  logic  taken;

  // op_b already holds the immediate for I and U forms
  always_comb begin
    case (dec.alu_op)
      ADD:     alu_res = dec.op_a + dec.op_b;
      SUB:     alu_res = dec.op_a - dec.op_b;
      AND:     alu_res = dec.op_a & dec.op_b;
      OR:      alu_res = dec.op_a | dec.op_b;
      XOR:     alu_res = dec.op_a ^ dec.op_b;
      PASS_B:  alu_res = dec.op_b;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////
  // next pc
  assign pc_plus4  = dec.pc + 64'd4;
  assign pc_target = dec.pc + dec.imm;
  assign br_eq     = (dec.op_a == dec.op_b);
  assign taken     = dec.is_jal || (dec.is_branch && (br_eq ^ dec.branch_ne));
  assign o_pc_next = taken ? pc_target : pc_plus4;

  // writeback, x0 never written
  assign o_rd       = dec.rd;
  assign o_rd_wen   = i_exec_en && dec.rd_wen && (dec.rd != '0);
  assign o_rd_wdata = dec.is_jal ? pc_plus4 : alu_res;

  // one strobe per putch, low byte of a0
  assign o_putch_valid = i_exec_en && dec.is_putch;
  assign o_putch_data  = dec.op_a[7:0];

endmodule

/* verilog/id_stage.sv */
// decode stage: field split, immediates, alu op mapping, registered decode bundle
`timescale 1ns/1ps

module id_stage import rv_isa_pkg::*, core_pkg::*; (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_decode_en,
  input  xlen_t         i_pc,
  input  inst_t         i_inst,
  output reg_idx_t      o_rs1,
  output reg_idx_t      o_rs2,
  input  xlen_t         i_rs1_data,
  input  xlen_t         i_rs2_data,
  decode_if.dec_mp      dec
);

  opcode_e  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  logic     putch_word;
  xlen_t    imm_i;
  xlen_t    imm_u;
  xlen_t    imm_b;
  xlen_t    imm_j;
  alu_op_e  f3_op;
  logic     f3_ok;

  alu_op_e  d_alu_op;
  xlen_t    d_op_b;
  xlen_t    d_imm;
  logic     d_rd_wen;
  logic     d_is_branch;
  logic     d_is_jal;

  assign opcode     = opcode_e'(i_inst[6:0]);
  assign funct3     = i_inst[14:12];
  assign funct7     = i_inst[31:25];
  assign putch_word = (i_inst == PUTCH_INST);

  // putch reads a0 regardless of its rs1 field
  assign o_rs1 = putch_word ? REG_A0 : i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      F3_ADD_SUB: f3_op = ADD;
      F3_XOR:     f3_op = XOR;
      F3_OR:      f3_op = OR;
      F3_AND:     f3_op = AND;
      default: begin
        f3_op = ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  // anything unmatched falls through as a no-op
  always_comb begin
    d_alu_op    = ADD;
    d_op_b      = i_rs2_data;
    d_imm       = imm_i;
    d_rd_wen    = 1'b0;
    d_is_branch = 1'b0;
    d_is_jal    = 1'b0;
    case (opcode)
      OP_IMM: begin
        d_alu_op = f3_op;
        d_op_b   = imm_i;
        d_rd_wen = f3_ok;
      end
      OP: begin
        d_alu_op = (funct7 == F7_SUB) ? SUB : f3_op;
        d_rd_wen = f3_ok && ((funct7 == F7_BASE) ||
                   (funct7 == F7_SUB && funct3 == F3_ADD_SUB));
      end
      LUI: begin
        d_alu_op = PASS_B;
        d_op_b   = imm_u;
        d_imm    = imm_u;
        d_rd_wen = 1'b1;
      end
      BRANCH: begin
        d_imm       = imm_b;
        d_is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      JAL: begin
        d_imm    = imm_j;
        d_is_jal = 1'b1;
        d_rd_wen = 1'b1;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // decode register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dec.rd_wen    <= 1'b0;
      dec.is_branch <= 1'b0;
      dec.is_jal    <= 1'b0;
      dec.is_putch  <= 1'b0;
    end else if (i_decode_en) begin
      dec.rd_wen    <= d_rd_wen;
      dec.is_branch <= d_is_branch;
      dec.is_jal    <= d_is_jal;
      dec.is_putch  <= (opcode == CUSTOM_PUTCH) && putch_word;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_decode_en) begin
      dec.alu_op    <= d_alu_op;
      dec.op_a      <= i_rs1_data;
      dec.op_b      <= d_op_b;
      dec.imm       <= d_imm;
      dec.rd        <= i_inst[11:7];
      dec.branch_ne <= (funct3 == F3_BNE);
      dec.pc        <= i_pc;
    end
  end

endmodule

/* verilog/if_stage.sv */
// fetch stage: pc, fetch handshake, instruction register and stage sequencer
`timescale 1ns/1ps

module if_stage import rv_isa_pkg::*, core_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h8000_0000
) (
  input  logic  i_clk,
  input  logic  i_rst_n,

  output logic  o_imem_req,
  output xlen_t o_imem_addr,
  input  logic  i_imem_ack,
  input  inst_t i_imem_rdata,

  input  xlen_t i_pc_next,
  output xlen_t o_pc,
  output inst_t o_inst,
  output logic  o_decode_en,
  output logic  o_exec_en
);

  seq_state_e state_q;
  xlen_t      pc_q;
  logic       req_q;
  inst_t      inst_q;

  //////////////////////////////
  // sequencer
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= S_FETCH;
      pc_q    <= RESET_PC;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        S_FETCH: begin
          // first request after reset
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (i_imem_ack) begin
            req_q   <= 1'b0;
            state_q <= S_DECODE;
          end
        end
        S_DECODE: begin
          state_q <= S_EXECUTE;
        end
        S_EXECUTE: begin
          pc_q    <= i_pc_next;
          req_q   <= 1'b1;
          state_q <= S_FETCH;
        end
        default: begin
          state_q <= S_FETCH;
        end
      endcase
    end
  end

  // instruction register, loaded on the ack beat
  always_ff @(posedge i_clk) begin
    if (state_q == S_FETCH && req_q && i_imem_ack) begin
      inst_q <= i_imem_rdata;
    end
  end

  assign o_imem_req  = req_q;
  assign o_imem_addr = pc_q;
  assign o_pc        = pc_q;
  assign o_inst      = inst_q;
  assign o_decode_en = (state_q == S_DECODE);
  assign o_exec_en   = (state_q == S_EXECUTE);

endmodule

/* verilog/regfile.sv */
// integer register file: 32 x 64, two combinational reads, one write
`timescale 1ns/1ps

module regfile import core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output xlen_t    o_rs1_data,
  output xlen_t    o_rs2_data,
  input  reg_idx_t i_rd,
  input  logic     i_rd_wen,
  input  xlen_t    i_rd_wdata
);

  localparam int NUM_REGS = 32;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  // x0 reads as zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* verilog/decode_if.sv */
// decoded instruction bundle from decode to execute
`timescale 1ns/1ps

interface decode_if import rv_isa_pkg::*, core_pkg::*; ();

  alu_op_e  alu_op;
  xlen_t    op_a;
  xlen_t    op_b;
  xlen_t    imm;
  reg_idx_t rd;
  logic     rd_wen;
  logic     is_branch;
  logic     branch_ne;
  logic     is_jal;
  logic     is_putch;
  xlen_t    pc;

  modport dec_mp (
    output alu_op, op_a, op_b, imm, rd, rd_wen,
    output is_branch, branch_ne, is_jal, is_putch, pc
  );

  modport exe_mp (
    input alu_op, op_a, op_b, imm, rd, rd_wen,
    input is_branch, branch_ne, is_jal, is_putch, pc
  );

endinterface

/* verilog/core_pkg.sv */
// core-wide types: data width, register index, sequencer states, putch word
package core_pkg;

  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // a0 holds the putch character
  localparam reg_idx_t REG_A0 = 5'd10;

  localparam logic [31:0] PUTCH_INST = 32'h0000_007b;

  // one instruction in flight at a time
  typedef enum logic [1:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE
  } seq_state_e;

endpackage

/* verilog/rv_isa_pkg.sv */
// rv64 instruction encodings: field widths and types, funct codes, opcode and alu enums
package rv_isa_pkg;

  localparam int INST_W   = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;
  typedef logic [FUNCT7_W-1:0] funct7_t;

  // major opcodes in use
  typedef enum logic [OPCODE_W-1:0] {
    OP_IMM       = 7'b0010011,
    OP           = 7'b0110011,
    LUI          = 7'b0110111,
    BRANCH       = 7'b1100011,
    JAL          = 7'b1101111,
    CUSTOM_PUTCH = 7'b1111011
  } opcode_e;

  // funct3 for alu and branch forms
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS_B
  } alu_op_e;

endpackage
